// ==== hw/fb_pkg.sv ====
/*
 * framebuffer shared types
 * pixel, word address and queue payload definitions
 */
package fb_pkg;

    typedef logic [15:0] pixel_t;
    typedef logic [23:0] addr_t;

    // host access as it travels through the command queue
    typedef struct packed {
        logic   wr;
        addr_t  addr;
        pixel_t data;
    } host_cmd_t;

    // eight pixels, oldest one in bits 127:112
    typedef logic [127:0] burst_data_t;

    localparam int BURST_LEN = 8;

endpackage

// ==== hw/fb_queue.sv ====
/*
 * fb_queue: synchronous circular FIFO for any payload type
 * head is shown on q_o, pop on deq_i
 */
`timescale 1ns/1ps

module fb_queue #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk_pix,
    input  logic  reset_i,

    input  logic  enq_i,
    input  item_t data_i,
    output logic  full_o,

    input  logic  deq_i,
    output item_t q_o,
    output logic  empty_o,
    output logic  alm_empty_o
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;

    assign q_o         = mem[rd_ptr];
    assign full_o      = (count == (PTR_BITS + 1)'(DEPTH));
    assign empty_o     = (count == '0);
    assign alm_empty_o = (count <= (PTR_BITS + 1)'(1));

    always_ff @(posedge clk_pix) begin
        if (enq_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq_i) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/fb_mem_ctrl.sv ====
/*
 * fb_mem_ctrl: on-chip RAM back-end behind the command queues
 * serves 8-word burst reads first, then single host reads and writes
 */
`timescale 1ns/1ps

module fb_mem_ctrl #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic                clk_pix,
    input  logic                reset_i,

    input  fb_pkg::host_cmd_t   cmd_q_i,
    input  logic                cmd_empty_i,
    output logic                cmd_deq_o,

    input  fb_pkg::addr_t       burst_addr_i,
    input  logic                burst_empty_i,
    output logic                burst_deq_o,

    output fb_pkg::pixel_t      rd_data_o,
    output logic                rd_enq_o,
    input  logic                rd_full_i,

    output fb_pkg::burst_data_t burst_data_o,
    output logic                burst_enq_o,
    input  logic                burst_full_i
);

    localparam int CNT_BITS = $clog2(fb_pkg::BURST_LEN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_BURST_PUSH,
        ST_READ_PUSH
    } state_t;

    state_t                   state;
    fb_pkg::pixel_t           ram [2**MEM_ADDR_BITS];
    logic [MEM_ADDR_BITS-1:0] mem_addr;
    logic [MEM_ADDR_BITS-1:0] cmd_addr;
    logic [CNT_BITS-1:0]      word_cnt;

    assign cmd_addr    = cmd_q_i.addr[MEM_ADDR_BITS-1:0];

    // burst requests win while the burst data queue has room
    assign burst_deq_o = (state == ST_IDLE) && !burst_empty_i && !burst_full_i;
    assign cmd_deq_o   = (state == ST_IDLE) && !burst_deq_o && !cmd_empty_i;
    assign burst_enq_o = (state == ST_BURST_PUSH) && !burst_full_i;
    assign rd_enq_o    = (state == ST_READ_PUSH) && !rd_full_i;

    always_ff @(posedge clk_pix) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    word_cnt <= '0;
                    if (burst_deq_o) begin
                        state <= ST_BURST;
                    end else if (cmd_deq_o && !cmd_q_i.wr) begin
                        state <= ST_READ_PUSH;
                    end
                end
                ST_BURST: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == CNT_BITS'(fb_pkg::BURST_LEN - 1)) begin
                        state <= ST_BURST_PUSH;
                    end
                end
                ST_BURST_PUSH: begin
                    if (!burst_full_i) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ_PUSH: begin
                    if (!rd_full_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // one word per cycle shifts in from the bottom
    always_ff @(posedge clk_pix) begin
        if (burst_deq_o) begin
            mem_addr <= burst_addr_i[MEM_ADDR_BITS-1:0];
        end else if (state == ST_BURST) begin
            burst_data_o <= {burst_data_o[111:0], ram[mem_addr]};
            mem_addr     <= mem_addr + 1'b1;
        end
        if (cmd_deq_o) begin
            if (cmd_q_i.wr) begin
                ram[cmd_addr] <= cmd_q_i.data;
            end else begin
                rd_data_o <= ram[cmd_addr];
            end
        end
    end

endmodule

// ==== hw/fb_pixel_shifter.sv ====
/*
 * fb_pixel_shifter: current and next burst for the video stream
 * one pixel per enable, asks for a refill after each burst swap
 */
`timescale 1ns/1ps

module fb_pixel_shifter (
    input  logic                clk_pix,
    input  logic                reset_i,

    input  logic                start_i,
    input  logic                ena_i,
    input  logic                load_now_i,
    input  logic                load_next_i,
    input  fb_pkg::burst_data_t next_burst_i,

    output logic                refill_req_o,
    output fb_pkg::pixel_t      pixel_o
);

    localparam int CNT_BITS = $clog2(fb_pkg::BURST_LEN);
    localparam int PIX_BITS = $bits(fb_pkg::pixel_t);

    logic [CNT_BITS-1:0] word_cnt;
    fb_pkg::burst_data_t cur_burst;
    fb_pkg::burst_data_t nxt_burst;
    logic                wrap;

    assign pixel_o = cur_burst[$bits(fb_pkg::burst_data_t)-1 -: PIX_BITS];
    assign wrap    = ena_i && (word_cnt == '0);

    always_ff @(posedge clk_pix) begin
        if (reset_i) begin
            word_cnt     <= '0;
            refill_req_o <= 1'b0;
        end else if (start_i) begin
            // pixel 0 already shows after preload
            word_cnt     <= CNT_BITS'(1);
            refill_req_o <= 1'b0;
        end else begin
            if (load_now_i || wrap) begin
                refill_req_o <= 1'b1;
            end else if (load_next_i) begin
                refill_req_o <= 1'b0;
            end
            if (ena_i) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (load_now_i) begin
            cur_burst <= next_burst_i;
            nxt_burst <= next_burst_i;
        end else begin
            if (wrap) begin
                cur_burst <= nxt_burst;
            end else if (ena_i) begin
                cur_burst <= cur_burst << PIX_BITS;
            end
            if (load_next_i) begin
                nxt_burst <= next_burst_i;
            end
        end
    end

endmodule

// ==== hw/fb_arbiter.sv ====
/*
 * fb_arbiter: shares the memory queues between host access,
 * frame preload, burst prefetch and shifter refill
 */
`timescale 1ns/1ps

module fb_arbiter #(
    parameter int FB_WIDTH      = 16,
    parameter int FB_HEIGHT     = 8,
    parameter int PRELOAD_DELAY = 16
) (
    input  logic                clk_pix,
    input  logic                reset_i,

    input  logic                sel_i,
    input  logic                wr_i,
    input  fb_pkg::addr_t       address_i,
    input  fb_pkg::pixel_t      data_i,
    output logic                ack_o,
    output fb_pkg::pixel_t      data_o,

    input  logic                start_i,
    input  fb_pkg::addr_t       base_i,
    input  logic                refill_req_i,
    output logic                preloading_o,
    output logic                underflow_o,

    output logic                load_now_o,
    output logic                load_next_o,
    output fb_pkg::burst_data_t next_burst_o,

    output logic                cmd_enq_o,
    output fb_pkg::host_cmd_t   cmd_d_o,
    input  logic                cmd_full_i,

    output logic                breq_enq_o,
    output fb_pkg::addr_t       breq_d_o,
    input  logic                breq_full_i,

    output logic                rd_deq_o,
    input  fb_pkg::pixel_t      rd_q_i,
    input  logic                rd_empty_i,

    output logic                burst_deq_o,
    input  fb_pkg::burst_data_t burst_q_i,
    input  logic                burst_empty_i,
    input  logic                burst_alm_empty_i
);

    localparam fb_pkg::addr_t BURST_STEP  = fb_pkg::addr_t'(fb_pkg::BURST_LEN);
    localparam fb_pkg::addr_t LAST_OFFSET =
        fb_pkg::addr_t'(FB_WIDTH * FB_HEIGHT - fb_pkg::BURST_LEN);

    typedef enum logic [3:0] {
        ST_IDLE, ST_WAIT_BURST, ST_WRITE0, ST_WRITE1,
        ST_READ0, ST_READ1, ST_READ2, ST_READ3,
        ST_REFILL0, ST_REFILL1, ST_PRELOAD_DELAY, ST_PRELOAD0,
        ST_PRELOAD1, ST_PRELOAD2, ST_PRELOAD3, ST_PRELOAD4
    } state_t;

    state_t        state;
    fb_pkg::addr_t burst_addr;
    fb_pkg::addr_t burst_addr_next;
    logic          preload_pend;
    logic [15:0]   delay_cnt;
    // bursts requested but not yet popped from the data queue
    logic [7:0]    inflight;

    // stop at the last burst of the frame
    assign burst_addr_next = (burst_addr < base_i + LAST_OFFSET) ?
                             burst_addr + BURST_STEP : burst_addr;

    always_ff @(posedge clk_pix) begin
        if (reset_i) begin
            state        <= ST_IDLE;
            ack_o        <= 1'b0;
            cmd_enq_o    <= 1'b0;
            breq_enq_o   <= 1'b0;
            rd_deq_o     <= 1'b0;
            burst_deq_o  <= 1'b0;
            load_now_o   <= 1'b0;
            load_next_o  <= 1'b0;
            preloading_o <= 1'b0;
            underflow_o  <= 1'b0;
            preload_pend <= 1'b0;
            burst_addr   <= '0;
            inflight     <= '0;
        end else begin
            inflight <= inflight + 8'(breq_enq_o) - 8'(burst_deq_o);

            case (state)
                ST_IDLE: begin
                    underflow_o <= 1'b0;
                    if (preload_pend) begin
                        preload_pend <= 1'b0;
                        delay_cnt    <= 16'(PRELOAD_DELAY);
                        state        <= ST_PRELOAD_DELAY;
                    end else if (!breq_full_i) begin
                        breq_d_o   <= burst_addr;
                        breq_enq_o <= 1'b1;
                        burst_addr <= burst_addr_next;
                        state      <= ST_WAIT_BURST;
                    end else if (refill_req_i) begin
                        state <= ST_REFILL0;
                    end else if (sel_i && !cmd_full_i && !burst_alm_empty_i) begin
                        state <= wr_i ? ST_WRITE0 : ST_READ0;
                    end
                end
                ST_WAIT_BURST: begin
                    breq_enq_o <= 1'b0;
                    state      <= ST_IDLE;
                end
                ST_WRITE0: begin
                    if (!cmd_full_i) begin
                        cmd_d_o   <= '{wr: 1'b1, addr: address_i, data: data_i};
                        cmd_enq_o <= 1'b1;
                        ack_o     <= 1'b1;
                        state     <= ST_WRITE1;
                    end
                end
                ST_WRITE1: begin
                    cmd_enq_o <= 1'b0;
                    ack_o     <= 1'b0;
                    state     <= ST_IDLE;
                end
                ST_READ0: begin
                    if (!cmd_full_i) begin
                        cmd_d_o   <= '{wr: 1'b0, addr: address_i, data: '0};
                        cmd_enq_o <= 1'b1;
                        state     <= ST_READ1;
                    end
                end
                ST_READ1: begin
                    cmd_enq_o <= 1'b0;
                    if (!rd_empty_i) begin
                        rd_deq_o <= 1'b1;
                        state    <= ST_READ2;
                    end
                end
                ST_READ2: begin
                    rd_deq_o <= 1'b0;
                    data_o   <= rd_q_i;
                    ack_o    <= 1'b1;
                    state    <= ST_READ3;
                end
                ST_READ3: begin
                    ack_o <= 1'b0;
                    state <= ST_IDLE;
                end
                ST_REFILL0: begin
                    // a burst on its way is waited for
                    if (!burst_empty_i) begin
                        burst_deq_o  <= 1'b1;
                        load_next_o  <= 1'b1;
                        next_burst_o <= burst_q_i;
                        state        <= ST_REFILL1;
                    end else if (inflight == '0) begin
                        underflow_o <= !preloading_o && !start_i;
                        state       <= ST_IDLE;
                    end
                end
                ST_REFILL1: begin
                    burst_deq_o <= 1'b0;
                    load_next_o <= 1'b0;
                    state       <= ST_IDLE;
                end
                ST_PRELOAD_DELAY: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt <= 16'd1) begin
                        state <= ST_PRELOAD0;
                    end
                end
                ST_PRELOAD0: begin
                    // drop every burst of the old frame
                    if (inflight == '0) begin
                        state <= ST_PRELOAD2;
                    end else if (!burst_empty_i) begin
                        burst_deq_o <= 1'b1;
                        state       <= ST_PRELOAD1;
                    end
                end
                ST_PRELOAD1: begin
                    burst_deq_o <= 1'b0;
                    state       <= ST_PRELOAD0;
                end
                ST_PRELOAD2: begin
                    if (!breq_full_i) begin
                        breq_d_o   <= burst_addr;
                        breq_enq_o <= 1'b1;
                        burst_addr <= burst_addr_next;
                        state      <= ST_PRELOAD3;
                    end
                end
                ST_PRELOAD3: begin
                    breq_enq_o <= 1'b0;
                    if (!burst_empty_i) begin
                        burst_deq_o  <= 1'b1;
                        load_now_o   <= 1'b1;
                        next_burst_o <= burst_q_i;
                        state        <= ST_PRELOAD4;
                    end
                end
                ST_PRELOAD4: begin
                    burst_deq_o  <= 1'b0;
                    load_now_o   <= 1'b0;
                    preloading_o <= 1'b0;
                    state        <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase

            // new frame overrides address and preload flags
            if (start_i) begin
                burst_addr   <= base_i;
                preload_pend <= 1'b1;
                preloading_o <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/framebuffer_top.sv ====
/*
 * framebuffer_top: host port and video stream over on-chip RAM
 * arbiter, pixel shifter, four queues and memory back-end
 */
`timescale 1ns/1ps

module framebuffer_top #(
    parameter int FB_WIDTH      = 16,
    parameter int FB_HEIGHT     = 8,
    parameter int MEM_ADDR_BITS = 8,
    parameter int PRELOAD_DELAY = 16,
    parameter int QUEUE_DEPTH   = 4
) (
    input  logic           clk_pix,
    input  logic           reset_i,

    input  logic           sel_i,
    input  logic           wr_i,
    input  fb_pkg::addr_t  address_i,
    input  fb_pkg::pixel_t data_i,
    output logic           ack_o,
    output fb_pkg::pixel_t data_o,

    input  logic           stream_start_frame_i,
    input  fb_pkg::addr_t  stream_base_address_i,
    input  logic           stream_ena_i,
    output fb_pkg::pixel_t stream_data_o,
    output logic           stream_preloading_o,
    output logic           stream_underflow_o
);

    logic                cmd_enq, cmd_deq, cmd_full, cmd_empty;
    fb_pkg::host_cmd_t   cmd_d, cmd_q;
    logic                breq_enq, breq_deq, breq_full, breq_empty;
    fb_pkg::addr_t       breq_d, breq_q;
    logic                rd_enq, rd_deq, rd_full, rd_empty;
    fb_pkg::pixel_t      rd_d, rd_q;
    logic                burst_enq, burst_deq, burst_full, burst_empty, burst_alm_empty;
    fb_pkg::burst_data_t burst_d, burst_q;
    logic                load_now, load_next, refill_req;
    fb_pkg::burst_data_t next_burst;

    fb_arbiter #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .PRELOAD_DELAY(PRELOAD_DELAY)
    ) arbiter_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .sel_i(sel_i), .wr_i(wr_i), .address_i(address_i), .data_i(data_i),
        .ack_o(ack_o), .data_o(data_o),
        .start_i(stream_start_frame_i), .base_i(stream_base_address_i),
        .refill_req_i(refill_req), .preloading_o(stream_preloading_o),
        .underflow_o(stream_underflow_o),
        .load_now_o(load_now), .load_next_o(load_next), .next_burst_o(next_burst),
        .cmd_enq_o(cmd_enq), .cmd_d_o(cmd_d), .cmd_full_i(cmd_full),
        .breq_enq_o(breq_enq), .breq_d_o(breq_d), .breq_full_i(breq_full),
        .rd_deq_o(rd_deq), .rd_q_i(rd_q), .rd_empty_i(rd_empty),
        .burst_deq_o(burst_deq), .burst_q_i(burst_q), .burst_empty_i(burst_empty),
        .burst_alm_empty_i(burst_alm_empty)
    );

    fb_pixel_shifter shifter_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .start_i(stream_start_frame_i), .ena_i(stream_ena_i),
        .load_now_i(load_now), .load_next_i(load_next), .next_burst_i(next_burst),
        .refill_req_o(refill_req), .pixel_o(stream_data_o)
    );

    fb_queue #(.item_t(fb_pkg::host_cmd_t), .DEPTH(QUEUE_DEPTH)) cmd_queue_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .enq_i(cmd_enq), .data_i(cmd_d), .full_o(cmd_full),
        .deq_i(cmd_deq), .q_o(cmd_q), .empty_o(cmd_empty), .alm_empty_o()
    );

    fb_queue #(.item_t(fb_pkg::addr_t), .DEPTH(QUEUE_DEPTH)) breq_queue_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .enq_i(breq_enq), .data_i(breq_d), .full_o(breq_full),
        .deq_i(breq_deq), .q_o(breq_q), .empty_o(breq_empty), .alm_empty_o()
    );

    fb_queue #(.item_t(fb_pkg::pixel_t), .DEPTH(QUEUE_DEPTH)) rd_queue_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .enq_i(rd_enq), .data_i(rd_d), .full_o(rd_full),
        .deq_i(rd_deq), .q_o(rd_q), .empty_o(rd_empty), .alm_empty_o()
    );

    fb_queue #(.item_t(fb_pkg::burst_data_t), .DEPTH(QUEUE_DEPTH)) burst_queue_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .enq_i(burst_enq), .data_i(burst_d), .full_o(burst_full),
        .deq_i(burst_deq), .q_o(burst_q), .empty_o(burst_empty),
        .alm_empty_o(burst_alm_empty)
    );

    fb_mem_ctrl #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_ctrl_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .cmd_q_i(cmd_q), .cmd_empty_i(cmd_empty), .cmd_deq_o(cmd_deq),
        .burst_addr_i(breq_q), .burst_empty_i(breq_empty), .burst_deq_o(breq_deq),
        .rd_data_o(rd_d), .rd_enq_o(rd_enq), .rd_full_i(rd_full),
        .burst_data_o(burst_d), .burst_enq_o(burst_enq), .burst_full_i(burst_full)
    );

endmodule

// ==== sim/fb_arbiter_assert.sv ====
/*
 * fb_arbiter_assert: protocol checks bound into fb_arbiter
 */
`timescale 1ns/1ps

module fb_arbiter_assert (
    input logic clk_pix,
    input logic reset_i,
    input logic ack_i,
    input logic rd_deq_i,
    input logic rd_empty_i,
    input logic burst_deq_i,
    input logic burst_empty_i,
    input logic preloading_i,
    input logic underflow_i
);

    // host acknowledge is a single-cycle pulse
    ack_single: assert property (@(posedge clk_pix) disable iff (reset_i)
        ack_i |=> !ack_i)
        else $error("ack_o high for two cycles in a row");

    rd_pop_safe: assert property (@(posedge clk_pix) disable iff (reset_i)
        rd_deq_i |-> !rd_empty_i)
        else $error("pop from empty read data queue");

    burst_pop_safe: assert property (@(posedge clk_pix) disable iff (reset_i)
        burst_deq_i |-> !burst_empty_i)
        else $error("pop from empty burst data queue");

    // no underflow while a preload is running
    preload_no_underflow: assert property (@(posedge clk_pix) disable iff (reset_i)
        !(preloading_i && underflow_i))
        else $error("preloading and underflow high together");

endmodule

bind fb_arbiter fb_arbiter_assert arbiter_assert_i (
    .clk_pix(clk_pix),
    .reset_i(reset_i),
    .ack_i(ack_o),
    .rd_deq_i(rd_deq_o),
    .rd_empty_i(rd_empty_i),
    .burst_deq_i(burst_deq_o),
    .burst_empty_i(burst_empty_i),
    .preloading_i(preloading_o),
    .underflow_i(underflow_o)
);

// ==== sim/tb_framebuffer.sv ====
/*
 * tb_framebuffer: table-driven testbench for framebuffer_top
 * host writes and reads, frame playout, host traffic during a frame
 */
`timescale 1ns/1ps

module tb_framebuffer;

    localparam int FB_WIDTH      = 16;
    localparam int FB_HEIGHT     = 8;
    localparam int MEM_ADDR_BITS = 8;
    localparam int PRELOAD_DELAY = 16;
    localparam int QUEUE_DEPTH   = 4;
    localparam int FRAME_WORDS   = FB_WIDTH * FB_HEIGHT;
    localparam int NUM_ROWS      = 2 * FRAME_WORDS + 3;
    localparam int MIX_ADDR      = 200;

    localparam int OP_WRITE     = 0;
    localparam int OP_READ      = 1;
    localparam int OP_FRAME     = 2;
    localparam int OP_FRAME_MIX = 3;

    logic           clk_pix;
    logic           reset_i;
    logic           sel_i;
    logic           wr_i;
    fb_pkg::addr_t  address_i;
    fb_pkg::pixel_t data_i;
    logic           ack_o;
    fb_pkg::pixel_t data_o;
    logic           stream_start_frame_i;
    fb_pkg::addr_t  stream_base_address_i;
    logic           stream_ena_i;
    fb_pkg::pixel_t stream_data_o;
    logic           stream_preloading_o;
    logic           stream_underflow_o;

    // stimulus table, one entry per row
    string          row_name [NUM_ROWS];
    int             row_op   [NUM_ROWS];
    fb_pkg::addr_t  row_addr [NUM_ROWS];
    fb_pkg::pixel_t row_data [NUM_ROWS];
    int             row_len  [NUM_ROWS];

    fb_pkg::pixel_t model [2**MEM_ADDR_BITS];
    int             cycles;
    int             cycle_limit;

    framebuffer_top #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .MEM_ADDR_BITS(MEM_ADDR_BITS),
        .PRELOAD_DELAY(PRELOAD_DELAY), .QUEUE_DEPTH(QUEUE_DEPTH)
    ) framebuffer_top_i (
        .clk_pix(clk_pix), .reset_i(reset_i),
        .sel_i(sel_i), .wr_i(wr_i), .address_i(address_i), .data_i(data_i),
        .ack_o(ack_o), .data_o(data_o),
        .stream_start_frame_i(stream_start_frame_i),
        .stream_base_address_i(stream_base_address_i),
        .stream_ena_i(stream_ena_i), .stream_data_o(stream_data_o),
        .stream_preloading_o(stream_preloading_o),
        .stream_underflow_o(stream_underflow_o)
    );

    initial clk_pix = 1'b0;
    always #10 clk_pix = ~clk_pix;

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("run timed out after %0d cycles waiting for the DUT", cycles);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check_pixel(input string name, input fb_pkg::pixel_t expected,
                               input fb_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %b actual %b", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // select held until the one-cycle ack
    task automatic host_access(input logic wr, input fb_pkg::addr_t addr,
                               input fb_pkg::pixel_t wdata,
                               output fb_pkg::pixel_t rdata);
        @(negedge clk_pix);
        sel_i     = 1'b1;
        wr_i      = wr;
        address_i = addr;
        data_i    = wdata;
        @(negedge clk_pix);
        while (!ack_o) begin
            @(negedge clk_pix);
        end
        rdata = data_o;
        sel_i = 1'b0;
        wr_i  = 1'b0;
    endtask

    // start strobe, wait for preload, then one enable every 4 cycles
    task automatic play_frame(input string name, input fb_pkg::addr_t base, input int len);
        @(negedge clk_pix);
        stream_base_address_i = base;
        stream_start_frame_i  = 1'b1;
        @(negedge clk_pix);
        stream_start_frame_i = 1'b0;
        while (stream_preloading_o) begin
            @(negedge clk_pix);
        end
        check_pixel($sformatf("%s pixel 0", name), model[int'(base)], stream_data_o);
        for (int n = 1; n < len; n++) begin
            check_flag($sformatf("%s underflow", name), 1'b0, stream_underflow_o);
            stream_ena_i = 1'b1;
            @(negedge clk_pix);
            stream_ena_i = 1'b0;
            check_pixel($sformatf("%s pixel %0d", name, n), model[int'(base) + n],
                        stream_data_o);
            repeat (3) begin
                check_flag($sformatf("%s underflow", name), 1'b0, stream_underflow_o);
                @(negedge clk_pix);
            end
        end
    endtask

    initial begin
        fb_pkg::pixel_t rdata;

        reset_i               = 1'b1;
        sel_i                 = 1'b0;
        wr_i                  = 1'b0;
        address_i             = '0;
        data_i                = '0;
        stream_start_frame_i  = 1'b0;
        stream_base_address_i = '0;
        stream_ena_i          = 1'b0;
        cycles                = 0;
        void'($urandom(93));

        for (int a = 0; a < FRAME_WORDS; a++) begin
            row_name[a]               = $sformatf("host write %0d", a);
            row_op[a]                 = OP_WRITE;
            row_addr[a]               = fb_pkg::addr_t'(a);
            row_data[a]               = fb_pkg::pixel_t'($urandom);
            row_len[a]                = 1;
            row_name[FRAME_WORDS + a] = $sformatf("host read %0d", a);
            row_op[FRAME_WORDS + a]   = OP_READ;
            row_addr[FRAME_WORDS + a] = fb_pkg::addr_t'(a);
            row_data[FRAME_WORDS + a] = '0;
            row_len[FRAME_WORDS + a]  = 1;
        end
        row_name[2*FRAME_WORDS]     = "frame base 0";
        row_op[2*FRAME_WORDS]       = OP_FRAME;
        row_addr[2*FRAME_WORDS]     = '0;
        row_data[2*FRAME_WORDS]     = '0;
        row_len[2*FRAME_WORDS]      = FRAME_WORDS;
        row_name[2*FRAME_WORDS + 1] = "frame base 32";
        row_op[2*FRAME_WORDS + 1]   = OP_FRAME;
        row_addr[2*FRAME_WORDS + 1] = fb_pkg::addr_t'(32);
        row_data[2*FRAME_WORDS + 1] = '0;
        row_len[2*FRAME_WORDS + 1]  = 64;
        // host write data for the access made during the frame
        row_name[2*FRAME_WORDS + 2] = "frame with host traffic";
        row_op[2*FRAME_WORDS + 2]   = OP_FRAME_MIX;
        row_addr[2*FRAME_WORDS + 2] = '0;
        row_data[2*FRAME_WORDS + 2] = fb_pkg::pixel_t'($urandom);
        row_len[2*FRAME_WORDS + 2]  = FRAME_WORDS;

        cycle_limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_op[r] == OP_WRITE || row_op[r] == OP_READ) begin
                cycle_limit += 40;
            end else begin
                cycle_limit += PRELOAD_DELAY + 60 + 4 * row_len[r];
            end
        end
        cycle_limit *= 2;

        repeat (10) @(negedge clk_pix);
        check_flag("reset ack_o", 1'b0, ack_o);
        check_flag("reset preloading", 1'b0, stream_preloading_o);
        check_flag("reset underflow", 1'b0, stream_underflow_o);
        reset_i = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            case (row_op[r])
                OP_WRITE: begin
                    host_access(1'b1, row_addr[r], row_data[r], rdata);
                    model[int'(row_addr[r])] = row_data[r];
                end
                OP_READ: begin
                    host_access(1'b0, row_addr[r], '0, rdata);
                    check_pixel(row_name[r], model[int'(row_addr[r])], rdata);
                end
                OP_FRAME: begin
                    play_frame(row_name[r], row_addr[r], row_len[r]);
                end
                default: begin
                    fork
                        play_frame(row_name[r], row_addr[r], row_len[r]);
                        begin
                            repeat (40) @(negedge clk_pix);
                            model[MIX_ADDR] = row_data[r];
                            host_access(1'b1, fb_pkg::addr_t'(MIX_ADDR), row_data[r], rdata);
                            host_access(1'b0, fb_pkg::addr_t'(MIX_ADDR), '0, rdata);
                            check_pixel({row_name[r], " host read"}, model[MIX_ADDR], rdata);
                        end
                    join
                end
            endcase
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== all.f ====
hw/fb_pkg.sv
hw/fb_queue.sv
hw/fb_mem_ctrl.sv
hw/fb_pixel_shifter.sv
hw/fb_arbiter.sv
hw/framebuffer_top.sv
sim/fb_arbiter_assert.sv
sim/tb_framebuffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the framebuffer testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_framebuffer -o sim_fb
./obj_dir/sim_fb > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
